// File: project.f
rtl/fpCvtPkg.sv
rtl/fpCvt96To32.sv
rtl/fpClassify96.sv
rtl/fpCvtMerge.sv
rtl/fpCvtUnit.sv
tb/fpCvtUnit_tb.sv

// File: Bender.yml
package:
  name: fp_cvt_unit

sources:
  - rtl/fpCvtPkg.sv
  - rtl/fpCvt96To32.sv
  - rtl/fpClassify96.sv
  - rtl/fpCvtMerge.sv
  - rtl/fpCvtUnit.sv
  - target: test
    files:
      - tb/fpCvtUnit_tb.sv

// File: tb/cvtPatterns.hex
// Columns: 96-bit input {sign, exp, sig}, expected single value, expected flags
// Flag bits from 4 down to 0: invalid, overflow, underflow, inexact, infinite
// Normal range, rebias and truncation
3FFF80000000000000000000 3F800000 00
BFFF80000000000000000000 BF800000 00
3FFFC0000000000000000001 3FC00000 02
3FFFFFFFFF00000000000000 3FFFFFFF 00
3FFFFFFFFF80000000000000 3FFFFFFF 02
407E80000000000000000000 7F000000 00
3F8180000000000000000000 00800000 00
4000A0000000000000000000 40200000 00
3FFEAAAAAAAAAAAAAAAAAAAA 3F2AAAAA 02
C0058000000000000000FFFF C2800000 02
// Infinity and NaN
7FFF80000000000000000000 7F800000 01
FFFF80000000000000000000 FF800000 01
7FFF00000000000000000000 7F800000 01
7FFFC0000000000000000000 7FC00000 10
7FFF8000000000000000000A 7F80000A 10
7FFF80000000000000000100 7F800000 10
FFFFFFFFF000000000000005 FFFFFFF5 10
// Finite values above the single range
407F80000000000000000000 7F800000 0A
C10080000000000000000000 FF800000 0A
7FFEFFFFFFFFFFFFFFFFFFFF 7F800000 0A
// Subnormal band
3F8080000000000000000000 00200000 04
3F8080000200000000000000 00200000 06
3F7EF0000000000000000000 000F0000 04
3F7EFFFFFE00000000000000 000FFFFF 06
3F6B80000000000000000000 00000001 04
3F6A80000000000000000000 00000000 06
// Below the subnormal band
3F6980000000000000000000 00000000 06
800180000000000000000000 80000000 06
000040000000000000000000 00000000 06
// Signed zeros
000000000000000000000000 00000000 00
800000000000000000000000 80000000 00

// File: tb/fpCvtUnit_tb.sv
`timescale 1ns/1ps

module fpCvtUnit_tb import fpCvtPkg::*; ();

	localparam int QueueDepth = 4;
	localparam int OutCredits = 2;
	localparam int MaxVectors = 64;

	logic clk;
	logic rstN;
	logic inValid;
	Fp96 inData;
	logic inCredit;
	logic outValid;
	CvtResult outData;
	logic outCreditReturn;

	// Three words per vector: input, expected value, expected flags
	logic [95:0] vecMem [0:3*MaxVectors-1];
	int numVectors;
	bit loaded;

	int errors;
	int outCount;
	int creditPulses;
	// Producer view of free queue slots
	int prodCredits;
	// Consumer copy of the credits the DUT holds, plus credits still to return
	int mirrorCredits;
	int owed;
	int returnWait;

	fpCvtUnit #(
		.QueueDepth(QueueDepth),
		.OutCredits(OutCredits)
	) uut (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.inData(inData),
		.inCredit(inCredit),
		.outValid(outValid),
		.outData(outData),
		.outCreditReturn(outCreditReturn)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
		end
	endtask

	// Advance to 1 ns after the next rising edge, where all DUT outputs have settled
	task automatic nextCycle();
		@(posedge clk);
		#1;
		if (inCredit === 1'b1)
			prodCredits++;
		if (prodCredits > QueueDepth) begin
			errors++;
			$display("Producer holds %0d credits, more than the queue depth", prodCredits);
		end
	endtask

	task automatic sendBeat(input int idx);
		inValid = 1'b1;
		inData = vecMem[3*idx];
		prodCredits--;
	endtask

	// ========================================
	// Scoreboard and consumer
	// ========================================

	always @(posedge clk) begin
		#1;
		// inCredit pulses exactly in the cycles that carry an output beat
		checkValue("inCredit", 32'(outValid), 32'(inCredit));
		if (outValid === 1'b1) begin
			if (mirrorCredits == 0) begin
				errors++;
				$display("outValid fired at %0t with no downstream credit held", $time);
			end
			else
				mirrorCredits--;
			if (outCount >= numVectors) begin
				errors++;
				$display("Surplus output at %0t beyond the %0d vectors", $time, numVectors);
			end
			else begin
				checkValue($sformatf("outData.value[%0d]", outCount),
					vecMem[3*outCount+1][31:0], outData.value);
				checkValue($sformatf("outData.flags[%0d]", outCount),
					32'(vecMem[3*outCount+2][4:0]), 32'(outData.flags));
			end
			outCount++;
			owed++;
		end
		if (inCredit === 1'b1)
			creditPulses++;
		// A return driven last cycle was taken by the DUT on this edge
		if (outCreditReturn)
			mirrorCredits++;
		if (owed > 0 && returnWait == 0) begin
			outCreditReturn = 1'b1;
			owed--;
			returnWait = $urandom % 4;
		end
		else begin
			outCreditReturn = 1'b0;
			if (returnWait > 0)
				returnWait--;
		end
	end

	// ========================================
	// Producer and end checks
	// ========================================

	initial begin
		int sent;
		void'($urandom(53410));
		inValid = 1'b0;
		inData = '0;
		rstN = 1'b0;
		outCreditReturn = 1'b0;
		errors = 0;
		outCount = 0;
		creditPulses = 0;
		prodCredits = QueueDepth;
		mirrorCredits = OutCredits;
		owed = 0;
		returnWait = 0;
		numVectors = 0;
		$readmemh("tb/cvtPatterns.hex", vecMem);
		while (numVectors < MaxVectors && !$isunknown(vecMem[3*numVectors]))
			numVectors++;
		loaded = 1'b1;
		if (numVectors == 0) begin
			errors++;
			$display("No test vectors were found in tb/cvtPatterns.hex");
		end

		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		// An idle unit right after reset shows no beat and no credit
		checkValue("outValid", 32'd0, 32'(outValid));
		checkValue("inCredit", 32'd0, 32'(inCredit));

		if (numVectors > 0) begin
			// Single beat into the empty queue must leave one cycle after it is sampled
			sendBeat(0);
			nextCycle();
			inValid = 1'b0;
			checkValue("outValid", 32'd0, 32'(outValid));
			nextCycle();
			checkValue("outValid", 32'd1, 32'(outValid));

			// The rest goes back to back, limited only by the producer credits
			sent = 1;
			while (sent < numVectors) begin
				if (prodCredits > 0) begin
					sendBeat(sent);
					sent++;
				end
				else
					inValid = 1'b0;
				nextCycle();
			end
			inValid = 1'b0;
			while (outCount < numVectors)
				nextCycle();
		end
		repeat (12) nextCycle();

		if (outCount != numVectors) begin
			errors++;
			$display("Expected %0d outputs but received %0d", numVectors, outCount);
		end
		if (creditPulses != outCount) begin
			errors++;
			$display("inCredit pulsed %0d times for %0d outputs", creditPulses, outCount);
		end
		if (prodCredits != QueueDepth) begin
			errors++;
			$display("Producer ended with %0d credits instead of %0d", prodCredits, QueueDepth);
		end

		$display("Errors: %0d, outputs: %0d of %0d, credit pulses: %0d",
			errors, outCount, numVectors, creditPulses);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Each vector gets 40 ns, plus room for reset and the drain at the end
	initial begin
		wait (loaded);
		#(numVectors * 40 + 200);
		$display("Timeout with only %0d of %0d outputs received", outCount, numVectors);
		$display("Errors: %0d, outputs: %0d of %0d, credit pulses: %0d",
			errors + 1, outCount, numVectors, creditPulses);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: rtl/fpCvtUnit.sv
`timescale 1ns/1ps

module fpCvtUnit import fpCvtPkg::*; #(
	parameter int QueueDepth = 4,
	parameter int OutCredits = 2
) (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input Fp96 inData,
	output logic inCredit,
	output logic outValid,
	output CvtResult outData,
	input logic outCreditReturn
);

	// ========================================
	// Combinational conversion stage
	// ========================================

	// Narrowed value and its flags, both valid in the same cycle as inData
	Fp32 cvtValue;
	CvtFlags cvtFlags;

	// Value path
	fpCvt96To32 cvt (
		.in(inData),
		.out(cvtValue)
	);

	// Flag path, looks at the same input in parallel
	fpClassify96 classify (
		.in(inData),
		.flags(cvtFlags)
	);

	// ========================================
	// Queue and flow control
	// ========================================

	// Result is written on the edge that samples inValid
	// The earliest it can leave is one cycle later
	fpCvtMerge #(
		.QueueDepth(QueueDepth),
		.OutCredits(OutCredits)
	) merge (
		.clk(clk),
		.rstN(rstN),
		.inValid(inValid),
		.value(cvtValue),
		.flags(cvtFlags),
		.outCreditReturn(outCreditReturn),
		.inCredit(inCredit),
		.outValid(outValid),
		.outData(outData)
	);

endmodule

// File: rtl/fpCvtMerge.sv
`timescale 1ns/1ps

module fpCvtMerge import fpCvtPkg::*; #(
	parameter int QueueDepth = 4,
	parameter int OutCredits = 2
) (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input Fp32 value,
	input CvtFlags flags,
	input logic outCreditReturn,
	output logic inCredit,
	output logic outValid,
	output CvtResult outData
);

	// Pointer width stays at one bit even for a single entry queue
	localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int CntW = $clog2(QueueDepth + 1);
	localparam int CredW = $clog2(OutCredits + 1);

	typedef logic [PtrW-1:0] QPtr;
	typedef logic [CntW-1:0] QCount;
	typedef logic [CredW-1:0] CredCount;

	// ========================================
	// Queue storage and state
	// ========================================

	CvtResult mem [QueueDepth];
	QPtr wrPtr;
	QPtr rdPtr;
	QCount count;

	// Credits currently held toward the consumer
	CredCount credits;

	// Entry that is written this cycle
	CvtResult newEntry;

	// Handshake decisions for the current cycle
	logic push;
	logic pop;

	always_comb begin
		newEntry.value = value;
		newEntry.flags = flags;
		push = inValid;
		// An entry leaves only with something queued and a slot free downstream
		pop = (count != '0) && (credits != '0);
	end

	// Circular increment that also works for depths that are not a power of two
	function automatic QPtr nextPtr(input QPtr ptr);
		if (ptr == QPtr'(QueueDepth - 1))
			return '0;
		return ptr + QPtr'(1);
	endfunction

	// Payload path, no reset needed on the array
	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= newEntry;
	end

	// Output data is registered on the pop edge together with outValid
	always_ff @(posedge clk) begin
		if (pop)
			outData <= mem[rdPtr];
	end

	// ========================================
	// Pointers and occupancy
	// ========================================

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			// Push and pop in the same cycle leave the count unchanged
			case ({push, pop})
				2'b10: count <= count + QCount'(1);
				2'b01: count <= count - QCount'(1);
				default: count <= count;
			endcase
		end
	end

	// ========================================
	// Downstream credits and upstream return
	// ========================================

	always_ff @(posedge clk) begin
		if (!rstN) begin
			credits <= CredCount'(OutCredits);
			outValid <= 1'b0;
			inCredit <= 1'b0;
		end
		else begin
			case ({pop, outCreditReturn})
				2'b10: credits <= credits - CredCount'(1);
				2'b01: credits <= credits + CredCount'(1);
				default: credits <= credits;
			endcase
			outValid <= pop;
			// Each pop frees a slot, so one credit goes back upstream
			inCredit <= pop;
		end
	end

	// ========================================
	// Protocol checks
	// ========================================

	// The producer may only send while it still holds a queue credit
	assert property (@(posedge clk) disable iff (!rstN)
		inValid |-> (count < QCount'(QueueDepth)))
		else $error("fpCvtMerge write while queue full");

	// The consumer must never return more credits than it was given
	assert property (@(posedge clk) disable iff (!rstN)
		credits <= CredCount'(OutCredits))
		else $error("fpCvtMerge credit counter above OutCredits");

endmodule

// File: rtl/fpClassify96.sv
`timescale 1ns/1ps

module fpClassify96 import fpCvtPkg::*; (
	input Fp96 in,
	output CvtFlags flags
);

	// Exponent class of the input
	logic isSpecial;
	logic isHuge;
	logic isTiny;

	// Any bit set anywhere in exponent or significand
	logic isNonZero;

	// Fraction bits below the integer bit, used to tell NaN from infinity
	logic fracNonZero;

	// Distance below NormLow, same shift the converter uses for subnormals
	Exp96 subShift;

	// Bits of the significand that fall off the bottom of the single field
	Sig96 lostMask;
	logic normLost;
	logic subLost;

	always_comb begin
		isSpecial = (in.exp == ExpMax96);
		isHuge = !isSpecial && (in.exp > NormHigh);
		isTiny = (in.exp < NormLow);
		isNonZero = (|in.exp) || (|in.sig);
		fracNonZero = |in.sig[78:0];
		subShift = NormLow - in.exp;
	end

	// ========================================
	// Lost bit detection
	// ========================================

	always_comb begin
		// A shift of 23 or more pushes the whole kept window out
		if (subShift > 15'd23)
			lostMask = '1;
		else
			lostMask = (Sig96'(1) << (subShift + 15'd57)) - Sig96'(1);

		// Normal results keep bits 78..56 and drop everything under them
		normLost = |in.sig[55:0];
		subLost = |(in.sig & lostMask);
	end

	// ========================================
	// Flag outputs
	// ========================================

	always_comb begin
		flags.invalid = isSpecial && fracNonZero;
		flags.infinite = isSpecial && !fracNonZero;
		flags.overflow = isHuge;
		flags.underflow = isTiny && isNonZero;

		// Saturation always loses precision
		// A tiny value is inexact only if something was shifted away
		if (isHuge)
			flags.inexact = 1'b1;
		else if (isTiny)
			flags.inexact = isNonZero && subLost;
		else if (!isSpecial)
			flags.inexact = normLost;
		else
			flags.inexact = 1'b0;
	end

endmodule

// File: rtl/fpCvt96To32.sv
`timescale 1ns/1ps

module fpCvt96To32 import fpCvtPkg::*; (
	input Fp96 in,
	output Fp32 out
);

	// Exponent after moving from the extended bias to the single bias
	Exp96 normExp;

	// Right shift applied to the significand in the subnormal band
	Exp96 subShift;

	always_comb begin
		normExp = in.exp - Bias96 + Exp96'(Bias32);
		subShift = NormLow - in.exp;
	end

	// ========================================
	// Range selection
	// ========================================

	always_comb begin
		// Sign passes through in every range, so zero and infinity stay signed
		out.sign = in.sign;

		if (in.exp == ExpMax96) begin
			// NaN or infinity
			// The top fraction bits carry the quiet bit and most of the payload
			// The low nibble is kept as well, so a payload tag in the bottom survives
			out.exp = 8'hFF;
			out.sig = {in.sig[78:60], in.sig[3:0]};
		end
		else if (in.exp > NormHigh) begin
			// Finite but too large for single, result saturates to infinity
			out.exp = 8'hFF;
			out.sig = '0;
		end
		else if (in.exp >= NormLow) begin
			// Normal range
			// Bit 79 is the explicit integer bit and is dropped here
			// The fraction is truncated, no rounding is done
			out.exp = Exp32'(normExp);
			out.sig = in.sig[78:56];
		end
		else if (in.exp >= SubLow) begin
			// Subnormal band
			// The integer bit is kept and the whole field slides right
			// The distance to NormLow sets how far it moves
			out.exp = '0;
			out.sig = Sig32'(in.sig[79:57] >> subShift);
		end
		else begin
			// Too small for even the smallest subnormal, flush to zero
			out.exp = '0;
			out.sig = '0;
		end
	end

endmodule

// File: rtl/fpCvtPkg.sv
package fpCvtPkg;

	// ========================================
	// Field widths
	// ========================================

	// Biased exponent of the 96-bit extended format
	typedef logic [14:0] Exp96;

	// Extended significand, explicit integer bit at position 79
	typedef logic [79:0] Sig96;

	// Biased exponent of IEEE single
	typedef logic [7:0] Exp32;

	// Single fraction field, the hidden bit is not stored
	typedef logic [22:0] Sig32;

	// ========================================
	// Value formats
	// ========================================

	// Sign sits on top so the struct maps straight onto the bus bits
	typedef struct packed {
		logic sign;
		Exp96 exp;
		Sig96 sig;
	} Fp96;

	typedef struct packed {
		logic sign;
		Exp32 exp;
		Sig32 sig;
	} Fp32;

	// Exception flags raised for one converted value
	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
		logic infinite;
	} CvtFlags;

	// One queued result, value in the upper 32 bits and flags in the low 5
	typedef struct packed {
		Fp32 value;
		CvtFlags flags;
	} CvtResult;

	// ========================================
	// Format constants
	// ========================================

	localparam Exp96 Bias96 = 15'h3FFF;
	localparam Exp32 Bias32 = 8'h7F;
	localparam Exp96 ExpMax96 = 15'h7FFF;

	// Extended exponents that land on single exponents 0x01 and 0xFE
	localparam Exp96 NormLow = 15'h3F81;
	localparam Exp96 NormHigh = 15'h407E;

	// Lower edge of the subnormal band, anything below flushes to zero
	localparam Exp96 SubLow = 15'h3F6A;

endpackage
